// ==== logic/dispatch_pkg.sv ====
`default_nettype none

package dispatch_pkg;

  // one beat on the memory bus and its byte address.
  localparam int WB_DATA_WIDTH = 32;
  localparam int WB_ADDR_WIDTH = 32;
  localparam int WB_SEL_WIDTH  = WB_DATA_WIDTH / 8;

  typedef logic [WB_DATA_WIDTH-1:0] wb_data_t;
  typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;
  typedef logic [WB_SEL_WIDTH-1:0]  wb_sel_t;

  // the HAND states mean that buffer is full and the other one is filling.
  typedef enum logic [1:0] {
    FILL_A,
    HAND_A,
    FILL_B,
    HAND_B
  } packer_state_e;

  typedef enum logic [1:0] {
    IDLE,
    BUS,  // strobe is up until the slave acks.
    NEXT  // one low cycle between beats.
  } writer_state_e;

endpackage

`default_nettype wire

// ==== logic/word_packer.sv ====
`timescale 1ns/100ps
`default_nettype none

module word_packer
  import dispatch_pkg::*;
#(
  parameter int WORD_WIDTH = 16,
  parameter int LINE_WIDTH = 128
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   en,
  input  wire                   push_data,
  input  wire  [WORD_WIDTH-1:0] data_in,
  input  wire                   available_write,
  output logic                  available_push,
  output logic                  request_write,
  output logic [LINE_WIDTH-1:0] write_data
);

  localparam int NUM = LINE_WIDTH / WORD_WIDTH;

  packer_state_e state;

  logic [LINE_WIDTH-1:0] buf_a;
  logic [LINE_WIDTH-1:0] buf_b;
  logic [NUM-1:0]        cnt_a;  // one-hot count where bit k set means k words held.
  logic [NUM-1:0]        cnt_b;

  logic accept;
  logic push_a;
  logic push_b;
  logic release_a;
  logic release_b;
  logic rel_a;  // first stage of the request pipeline.
  logic rel_b;

  assign accept = en & push_data & available_push;

  // A fills in FILL_A and while B waits; B fills in FILL_B and while A waits.
  assign push_a = accept & ((state == FILL_A) | (state == HAND_B));
  assign push_b = accept & ((state == FILL_B) | (state == HAND_A));

  assign release_a = en & available_write & (state == HAND_A);
  assign release_b = en & available_write & (state == HAND_B);

  // new words enter at the top, so the first word ends up in the low bits.
  always_ff @(posedge clk) begin
    if (push_a) begin
      buf_a <= {data_in, buf_a[LINE_WIDTH-1:WORD_WIDTH]};
    end
    if (push_b) begin
      buf_b <= {data_in, buf_b[LINE_WIDTH-1:WORD_WIDTH]};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= FILL_A;
      cnt_a <= NUM'(1);
      cnt_b <= NUM'(1);
    end else begin
      if (release_a) begin
        cnt_a <= NUM'(1);
      end else if (push_a) begin
        cnt_a <= cnt_a << 1;
      end

      if (release_b) begin
        cnt_b <= NUM'(1);
      end else if (push_b) begin
        cnt_b <= cnt_b << 1;
      end

      // the waiting side never fills up completely because available_push stops it.
      case (state)
        FILL_A: begin
          if (push_a && cnt_a[NUM-1]) begin
            state <= HAND_A;
          end
        end
        HAND_A: begin
          if (release_a) begin
            state <= FILL_B;
          end
        end
        FILL_B: begin
          if (push_b && cnt_b[NUM-1]) begin
            state <= HAND_B;
          end
        end
        HAND_B: begin
          if (release_b) begin
            state <= FILL_A;
          end
        end
        default: state <= FILL_A;
      endcase
    end
  end

  // stop the CGRA one word short of a second full line.
  always_ff @(posedge clk) begin
    if (rst) begin
      available_push <= 1'b1;
    end else if (release_a || release_b) begin
      available_push <= 1'b1;
    end else if ((push_b && (state == HAND_A) && cnt_b[NUM-2]) ||
                 (push_a && (state == HAND_B) && cnt_a[NUM-2])) begin
      available_push <= 1'b0;
    end
  end

  // the handoff runs on even with en low, so a released line always leaves.
  always_ff @(posedge clk) begin
    if (rst) begin
      rel_a         <= 1'b0;
      rel_b         <= 1'b0;
      request_write <= 1'b0;
    end else begin
      rel_a         <= release_a;
      rel_b         <= release_b;
      request_write <= rel_a | rel_b;
    end
  end

  always_ff @(posedge clk) begin
    if (rel_a) begin
      write_data <= buf_a;
    end else if (rel_b) begin
      write_data <= buf_b;
    end
  end

endmodule

`default_nettype wire

// ==== logic/line_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module line_fifo #(
  parameter int LINE_WIDTH = 128,
  parameter int FIFO_DEPTH = 4
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   push,
  input  wire  [LINE_WIDTH-1:0] wr_data,
  input  wire                   pop,
  output logic [LINE_WIDTH-1:0] rd_data,
  output logic                  empty,
  output logic                  room
);

  localparam int PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

  localparam logic [PTR_WIDTH-1:0] LAST_SLOT  = PTR_WIDTH'(FIFO_DEPTH - 1);
  localparam logic [CNT_WIDTH-1:0] FULL_COUNT = CNT_WIDTH'(FIFO_DEPTH);
  localparam logic [CNT_WIDTH-1:0] ROOM_LIMIT = CNT_WIDTH'(FIFO_DEPTH - 2);

  logic [LINE_WIDTH-1:0] mem [FIFO_DEPTH];
  logic [PTR_WIDTH-1:0]  wr_ptr;
  logic [PTR_WIDTH-1:0]  rd_ptr;
  logic [CNT_WIDTH-1:0]  count;

  logic do_push;
  logic do_pop;

  assign do_push = push && (count != FULL_COUNT);
  assign do_pop  = pop && !empty;

  assign rd_data = mem[rd_ptr];  // head of the queue is visible without a pop.
  assign empty   = (count == '0);
  assign room    = (count <= ROOM_LIMIT);  // two free slots for the lines in the packer.

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/wb_line_writer.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_line_writer
  import dispatch_pkg::*;
#(
  parameter int LINE_WIDTH = 128
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire  wb_addr_t        base_addr,
  input  wire                   line_valid,
  input  wire  [LINE_WIDTH-1:0] line_data,
  input  wire                   wb_ack,
  output logic                  line_pop,
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output logic                  wb_we,
  output wb_addr_t              wb_adr,
  output wb_sel_t               wb_sel,
  output wb_data_t              wb_dat_w
);

  localparam int BEATS      = LINE_WIDTH / WB_DATA_WIDTH;
  localparam int BEAT_WIDTH = (BEATS > 1) ? $clog2(BEATS) : 1;

  localparam logic [BEAT_WIDTH-1:0] LAST_BEAT  = BEAT_WIDTH'(BEATS - 1);
  localparam wb_addr_t              BEAT_BYTES = wb_addr_t'(WB_DATA_WIDTH / 8);

  writer_state_e state;

  logic [LINE_WIDTH-1:0] line_q;
  logic [BEAT_WIDTH-1:0] beat;
  wb_addr_t              addr_q;
  logic                  bus_active;

  // take a new line only from IDLE.
  assign line_pop   = (state == IDLE) && line_valid;
  assign bus_active = (state == BUS);

  // in a classic single write cyc and stb move together.
  assign wb_cyc   = bus_active;
  assign wb_stb   = bus_active;
  assign wb_we    = 1'b1;
  assign wb_sel   = '1;  // always full words.
  assign wb_adr   = addr_q;
  assign wb_dat_w = line_q[beat * WB_DATA_WIDTH +: WB_DATA_WIDTH];

  always_ff @(posedge clk) begin
    if (line_pop) begin
      line_q <= line_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= IDLE;
      beat   <= '0;
      addr_q <= base_addr;
    end else begin
      case (state)
        IDLE: begin
          if (line_valid) begin
            beat  <= '0;
            state <= BUS;
          end
        end
        BUS: begin
          // address keeps running across lines.
          if (wb_ack) begin
            addr_q <= addr_q + BEAT_BYTES;
            state  <= NEXT;
          end
        end
        NEXT: begin
          if (beat == LAST_BEAT) begin
            state <= IDLE;
          end else begin
            beat  <= beat + 1'b1;
            state <= BUS;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/cgra_result_dispatch.sv ====
`timescale 1ns/100ps
`default_nettype none

module cgra_result_dispatch
  import dispatch_pkg::*;
#(
  parameter int WORD_WIDTH = 16,
  parameter int LINE_WIDTH = 128,  // multiple of WORD_WIDTH and of the bus width.
  parameter int FIFO_DEPTH = 4
) (
  input  wire                   clk,
  input  wire                   rst,

  input  wire                   en,
  input  wire                   push_data,
  input  wire  [WORD_WIDTH-1:0] data_in,
  output logic                  available_push,

  input  wire  wb_addr_t        base_addr,

  output logic                  wb_cyc,
  output logic                  wb_stb,
  output logic                  wb_we,
  output wb_addr_t              wb_adr,
  output wb_sel_t               wb_sel,
  output wb_data_t              wb_dat_w,
  input  wire                   wb_ack
);

  logic                  request_write;
  logic [LINE_WIDTH-1:0] write_data;
  logic                  fifo_room;
  logic                  fifo_empty;
  logic [LINE_WIDTH-1:0] fifo_rd_data;
  logic                  line_pop;

  word_packer #(
    .WORD_WIDTH(WORD_WIDTH),
    .LINE_WIDTH(LINE_WIDTH)
  ) u_packer (
    .clk            (clk),
    .rst            (rst),
    .en             (en),
    .push_data      (push_data),
    .data_in        (data_in),
    .available_write(fifo_room),
    .available_push (available_push),
    .request_write  (request_write),
    .write_data     (write_data)
  );

  line_fifo #(
    .LINE_WIDTH(LINE_WIDTH),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .clk    (clk),
    .rst    (rst),
    .push   (request_write),
    .wr_data(write_data),
    .pop    (line_pop),
    .rd_data(fifo_rd_data),
    .empty  (fifo_empty),
    .room   (fifo_room)
  );

  wb_line_writer #(
    .LINE_WIDTH(LINE_WIDTH)
  ) u_writer (
    .clk       (clk),
    .rst       (rst),
    .base_addr (base_addr),
    .line_valid(~fifo_empty),
    .line_data (fifo_rd_data),
    .wb_ack    (wb_ack),
    .line_pop  (line_pop),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_sel    (wb_sel),
    .wb_dat_w  (wb_dat_w)
  );

endmodule

`default_nettype wire

// ==== sim/wb_memory_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_memory_model
  import dispatch_pkg::*;
#(
  parameter int     MEM_WORDS = 1024,
  parameter integer SEED      = 1
) (
  input  wire           clk,
  input  wire           rst,
  input  wire  [7:0]    max_wait,
  input  wire           wb_cyc,
  input  wire           wb_stb,
  input  wire           wb_we,
  input  wire wb_addr_t wb_adr,
  input  wire wb_sel_t  wb_sel,
  input  wire wb_data_t wb_dat_w,
  output logic          wb_ack
);

  localparam int IDX_WIDTH = $clog2(MEM_WORDS);

  wb_data_t             mem [MEM_WORDS];
  integer               seed;
  int                   waited;
  int                   delay;
  int                   lane;
  logic [IDX_WIDTH-1:0] idx;

  assign idx = wb_adr[IDX_WIDTH+1:2];  // word index that wraps the array on higher bits.

  initial begin
    int fill;
    seed = SEED;
    wb_ack <= 1'b0;
    for (fill = 0; fill < MEM_WORDS; fill++) begin
      mem[fill] = ~wb_data_t'(fill * 4);  // unwritten words read as the inverted byte address.
    end
  end

  // ack comes after 0 to max_wait extra cycles and lasts one cycle.
  always @(posedge clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
      waited <= 0;
      delay  <= 0;
    end else if (wb_ack) begin
      wb_ack <= 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (waited >= delay) begin
        wb_ack <= 1'b1;
        waited <= 0;
        delay  <= $unsigned($random(seed)) % (max_wait + 1);
      end else begin
        waited <= waited + 1;
      end
    end
  end

  always @(posedge clk) begin
    if (!rst && wb_cyc && wb_stb && wb_we && wb_ack) begin
      for (lane = 0; lane < WB_SEL_WIDTH; lane++) begin
        if (wb_sel[lane]) begin
          mem[idx][lane*8 +: 8] <= wb_dat_w[lane*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== sim/dispatch_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module dispatch_tb
  import dispatch_pkg::*;
();

  localparam int       WORD_WIDTH     = 16;
  localparam int       LINE_WIDTH     = 128;
  localparam int       FIFO_DEPTH     = 4;
  localparam int       MEM_WORDS      = 1024;
  localparam int       NUM_WORDS      = LINE_WIDTH / WORD_WIDTH;
  localparam int       BEATS          = LINE_WIDTH / WB_DATA_WIDTH;
  localparam int       TOTAL_LINES    = 18;
  localparam int       TOTAL_BEATS    = TOTAL_LINES * BEATS;
  localparam int       TIMEOUT_CYCLES = TOTAL_LINES * BEATS * 10 + 2000;
  localparam wb_addr_t BASE_ADDR      = 32'h0000_2000;

  localparam logic [WORD_WIDTH-1:0] DISABLED_WORD = '1;  // never part of the sequence.

  logic                  clk;
  logic                  rst;
  logic                  en;
  logic                  push_data;
  logic [WORD_WIDTH-1:0] data_in;
  logic                  available_push;
  wb_addr_t              base_addr;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  wb_addr_t              wb_adr;
  wb_sel_t               wb_sel;
  wb_data_t              wb_dat_w;
  logic                  wb_ack;
  logic [7:0]            max_wait;

  integer                seed;
  int                    errors = 0;
  int                    pushed = 0;
  int                    beats_checked = 0;
  int                    beat_in_line = 0;
  int                    i;
  bit                    saw_stall = 1'b0;
  logic [WORD_WIDTH-1:0] words [$];    // accepted words not yet seen on the bus.
  wb_data_t              written [$];  // expected data of every beat in address order.
  logic [LINE_WIDTH-1:0] exp_line;
  wb_data_t              exp_dat;
  wb_addr_t              exp_adr;

  cgra_result_dispatch #(
    .WORD_WIDTH(WORD_WIDTH),
    .LINE_WIDTH(LINE_WIDTH),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) UUT (
    .clk           (clk),
    .rst           (rst),
    .en            (en),
    .push_data     (push_data),
    .data_in       (data_in),
    .available_push(available_push),
    .base_addr     (base_addr),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_sel        (wb_sel),
    .wb_dat_w      (wb_dat_w),
    .wb_ack        (wb_ack)
  );

  wb_memory_model #(
    .MEM_WORDS(MEM_WORDS),
    .SEED     (32'hb95b_00ab)
  ) mem_model (
    .clk     (clk),
    .rst     (rst),
    .max_wait(max_wait),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_we   (wb_we),
    .wb_adr  (wb_adr),
    .wb_sel  (wb_sel),
    .wb_dat_w(wb_dat_w),
    .wb_ack  (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  stb_needs_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
    else begin
      errors = errors + 1;
      $display("protocol failure at %0t: wb_stb high without wb_cyc", $time);
    end

  ack_needs_stb: assert property (@(posedge clk) disable iff (rst) wb_ack |-> wb_stb)
    else begin
      errors = errors + 1;
      $display("protocol failure at %0t: wb_ack arrived with no strobe up", $time);
    end

  one_ack_per_stb: assert property (@(posedge clk) disable iff (rst)
      wb_stb && wb_ack |=> !wb_stb)
    else begin
      errors = errors + 1;
      $display("protocol failure at %0t: strobe stayed up after its ack", $time);
    end

  stb_held_until_ack: assert property (@(posedge clk) disable iff (rst)
      wb_stb && !wb_ack |=> wb_cyc && wb_stb)
    else begin
      errors = errors + 1;
      $display("protocol failure at %0t: strobe dropped before its ack", $time);
    end

  stable_while_waiting: assert property (@(posedge clk) disable iff (rst)
      wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_dat_w))
    else begin
      errors = errors + 1;
      $display("protocol failure at %0t: address or data moved before the ack", $time);
    end

  // a word counts as taken on every edge where en, push_data and available_push are high.
  always @(posedge clk) begin
    if (!rst && en && push_data && available_push) begin
      words.push_back(data_in);
    end
    if (!rst && !available_push) begin
      saw_stall = 1'b1;
    end
  end

  always @(posedge clk) begin
    if (!rst && wb_cyc && wb_stb && wb_ack) begin
      if (beat_in_line == 0) begin
        if (words.size() < NUM_WORDS) begin
          errors = errors + 1;
          $display("line written at %0t before enough words were accepted", $time);
        end else begin
          for (i = 0; i < NUM_WORDS; i++) begin
            exp_line[i*WORD_WIDTH +: WORD_WIDTH] = words.pop_front();
          end
        end
      end
      exp_dat = exp_line[beat_in_line*WB_DATA_WIDTH +: WB_DATA_WIDTH];
      exp_adr = BASE_ADDR + wb_addr_t'(beats_checked * 4);
      assert (wb_dat_w == exp_dat) else begin
        errors = errors + 1;
        $display("ERROR at %0t: wb_dat_w expected %h got %h", $time, exp_dat, wb_dat_w);
      end
      assert (wb_adr == exp_adr) else begin
        errors = errors + 1;
        $display("ERROR at %0t: wb_adr expected %h got %h", $time, exp_adr, wb_adr);
      end
      assert (wb_we == 1'b1) else begin
        errors = errors + 1;
        $display("ERROR at %0t: wb_we expected 1 got %b", $time, wb_we);
      end
      assert (wb_sel == '1) else begin
        errors = errors + 1;
        $display("ERROR at %0t: wb_sel expected %h got %h", $time, wb_sel_t'('1), wb_sel);
      end
      written.push_back(exp_dat);
      beats_checked = beats_checked + 1;
      beat_in_line = (beat_in_line == BEATS - 1) ? 0 : beat_in_line + 1;
    end
  end

  // one clock of stimulus, offering words only while fewer than limit were taken.
  task automatic drive_cycle(input bit enable, input int limit);
    integer rnd;
    @(posedge clk);
    if (en && push_data && available_push) begin
      pushed = pushed + 1;
    end
    rnd = $random(seed);
    en        <= enable;
    push_data <= (pushed < limit) && (rnd[1:0] != 2'b00);
    data_in   <= enable ? WORD_WIDTH'(pushed) : DISABLED_WORD;
  endtask

  task automatic push_until(input int target);
    while (pushed < target) begin
      drive_cycle(1'b1, target);
    end
  endtask

  task automatic hold_disabled(input int cycles);
    repeat (cycles) begin
      drive_cycle(1'b0, pushed + 1);
    end
  endtask

  task automatic check_after_reset();
    assert (!wb_cyc) else begin
      errors = errors + 1;
      $display("ERROR at %0t: wb_cyc expected 0 got %b", $time, wb_cyc);
    end
    assert (!wb_stb) else begin
      errors = errors + 1;
      $display("ERROR at %0t: wb_stb expected 0 got %b", $time, wb_stb);
    end
    assert (available_push) else begin
      errors = errors + 1;
      $display("ERROR at %0t: available_push expected 1 got %b", $time, available_push);
    end
  endtask

  task automatic check_memory();
    int k;
    wb_addr_t adr;
    wb_data_t got;
    for (k = 0; k < written.size(); k++) begin
      adr = BASE_ADDR + wb_addr_t'(k * 4);
      got = mem_model.mem[(adr >> 2) % MEM_WORDS];
      assert (got == written[k]) else begin
        errors = errors + 1;
        $display("ERROR at %0t: mem[%h] expected %h got %h", $time, adr, written[k], got);
      end
    end
  endtask

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: %0d of %0d beats written when time ran out", beats_checked, TOTAL_BEATS);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    seed      = 32'hb95b_00ab;
    rst       = 1'b1;
    en        = 1'b1;
    push_data = 1'b0;
    data_in   = '0;
    base_addr = BASE_ADDR;
    max_wait  = 8'd6;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_after_reset();
    push_until(6 * NUM_WORDS);
    max_wait <= 8'd30;  // slow acks back up the FIFO into the packer.
    push_until(14 * NUM_WORDS);
    max_wait <= 8'd6;
    push_until(16 * NUM_WORDS + 3);
    hold_disabled(30);  // drop en in the middle of a line.
    push_until(TOTAL_LINES * NUM_WORDS);
    while (beats_checked < TOTAL_BEATS) begin
      @(posedge clk);
    end
    repeat (40) @(posedge clk);
    assert (beats_checked == TOTAL_BEATS) else begin
      errors = errors + 1;
      $display("ERROR at %0t: beats expected %0d got %0d", $time, TOTAL_BEATS, beats_checked);
    end
    assert (words.size() == 0) else begin
      errors = errors + 1;
      $display("%0d accepted words never reached the bus", words.size());
    end
    assert (saw_stall) else begin
      errors = errors + 1;
      $display("available_push never fell during the slow ack phase");
    end
    check_memory();
    $display("summary: %0d errors, %0d of %0d beats checked", errors, beats_checked,
             TOTAL_BEATS);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
logic/dispatch_pkg.sv
logic/word_packer.sv
logic/line_fifo.sv
logic/wb_line_writer.sv
logic/cgra_result_dispatch.sv
sim/wb_memory_model.sv
sim/dispatch_tb.sv

// ==== Bender.yml ====
package:
  name: cgra_result_dispatch

sources:
  # design sources in compile order
  - files:
      - logic/dispatch_pkg.sv
      - logic/word_packer.sv
      - logic/line_fifo.sv
      - logic/wb_line_writer.sv
      - logic/cgra_result_dispatch.sv

  # testbench and bus model
  - target: simulation
    files:
      - sim/wb_memory_model.sv
      - sim/dispatch_tb.sv
